// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_host_domain
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= -Wall
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINTFLAGS) -f sim.f --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f sim.f --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
source/host_geom_pkg.sv
source/host_bus_pkg.sv
source/l2_bank_array.sv
source/llc_tag_tracker.sv
source/llc_cfg_regs.sv
source/host_domain.sv
sim/host_domain_asserts.sv
sim/tb_host_domain.sv

// File: sim/host_domain_asserts.sv
// Host domain protocol checks
// Response timing on both ports and exclusive tracker events
`timescale 1ns/100ps
`default_nettype none

module host_domain_asserts (
  input logic                      clk_i,
  input logic                      rst_i,
  input host_bus_pkg::mem_req_t    mem_req_i,
  input host_bus_pkg::mem_rsp_t    mem_rsp_i,
  input host_bus_pkg::cfg_req_t    cfg_req_i,
  input host_bus_pkg::cfg_rsp_t    cfg_rsp_i,
  input host_bus_pkg::llc_events_t events_i
);

  mem_rsp_follows_req: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_i.valid |=> mem_rsp_i.valid)
    else $error("memory response missing one cycle after request");

  mem_rsp_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    !mem_req_i.valid |=> !mem_rsp_i.valid)
    else $error("memory response without request");

  cfg_rsp_follows_req: assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_req_i.valid |=> cfg_rsp_i.valid)
    else $error("register response missing one cycle after request");

  cfg_rsp_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    !cfg_req_i.valid |=> !cfg_rsp_i.valid)
    else $error("register response without request");

  events_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(events_i))
    else $error("more than one tracker event high");

endmodule

bind host_domain host_domain_asserts u_host_domain_asserts (
  .clk_i     ( clk_i      ),
  .rst_i     ( rst_i      ),
  .mem_req_i ( mem_req_i  ),
  .mem_rsp_i ( mem_rsp_o  ),
  .cfg_req_i ( cfg_req_i  ),
  .cfg_rsp_i ( cfg_rsp_o  ),
  .events_i  ( llc_events )
);

`default_nettype wire

// File: sim/tb_host_domain.sv
// Host domain testbench
// Directed tests of the L2 data path, the register block and the
// hit and miss counters, checked against a reference model
`timescale 1ns/100ps
`default_nettype none

module tb_host_domain;

  import host_geom_pkg::*;
  import host_bus_pkg::*;

  logic     clk_i;
  logic     rst_i;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;
  cfg_req_t cfg_req;
  cfg_rsp_t cfg_rsp;

  // Reference model
  logic [DATA_W-1:0]    ref_mem [int unsigned];
  llc_region_t          ref_region;
  logic [LLC_TAG_W-1:0] ref_tag [LLC_NUM_LINES];
  logic                 ref_valid [LLC_NUM_LINES];
  int unsigned          ref_cnt [4];  // read hit, read miss, write hit, write miss
  int                   errors;
  int                   checks;
  int                   tests;

  host_domain dut_i (
    .clk_i     ( clk_i   ),
    .rst_i     ( rst_i   ),
    .mem_req_i ( mem_req ),
    .mem_rsp_o ( mem_rsp ),
    .cfg_req_i ( cfg_req ),
    .cfg_rsp_o ( cfg_rsp )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_eq(input string name, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    $display("test %-14s %0d errors", name, errors - err0);
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Classification and tag bookkeeping of one accepted access
  task automatic model_access(input logic [ADDR_W-1:0] addr, input logic we);
    logic [LLC_INDEX_W-1:0] idx;
    logic [LLC_TAG_W-1:0]   tag;
    int                     kind;
    idx = addr[12:5];
    tag = addr[31:13];
    if (addr < ref_region.spm_start && addr >= ref_region.cache_start &&
        addr < ref_region.cache_end) begin
      kind = (ref_valid[idx] && ref_tag[idx] == tag) ? 0 : 1;
      ref_valid[idx] = 1'b1;
      ref_tag[idx]   = tag;
      ref_cnt[kind + (we ? 2 : 0)]++;
    end
  endtask

  task automatic mem_access(input logic we, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    int cycles;
    mem_req = '{valid: 1'b1, we: we, addr: addr, wdata: wdata};
    model_access(addr, we);
    idle_cycle();
    mem_req.valid = 1'b0;
    cycles = 0;
    while (!mem_rsp.valid && cycles < 20) begin
      idle_cycle();
      cycles++;
    end
    if (!mem_rsp.valid) begin
      $display("No memory response within 20 cycles for address %h at %0t ns", addr, $time);
      errors++;
    end
    rdata = mem_rsp.rdata;
  endtask

  task automatic mem_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] rdata;
    mem_access(1'b1, addr, data, rdata);
    ref_mem[addr[14:2]] = data;
  endtask

  task automatic mem_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    mem_access(1'b0, addr, '0, data);
  endtask

  task automatic check_mem(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] data;
    mem_read(addr, data);
    if (ref_mem.exists(addr[14:2])) begin
      check_eq("mem_rsp_o.rdata", data, ref_mem[addr[14:2]]);
    end
  endtask

  task automatic cfg_access(input logic we, input logic [CFG_ADDR_W-1:0] offset,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    int cycles;
    cfg_req = '{valid: 1'b1, we: we, offset: offset, wdata: wdata};
    idle_cycle();
    cfg_req.valid = 1'b0;
    cycles = 0;
    while (!cfg_rsp.valid && cycles < 20) begin
      idle_cycle();
      cycles++;
    end
    if (!cfg_rsp.valid) begin
      $display("No register response within 20 cycles for offset %h at %0t ns", offset, $time);
      errors++;
    end
    rdata = cfg_rsp.rdata;
  endtask

  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] offset, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] rdata;
    cfg_access(1'b1, offset, data, rdata);
    case (offset)
      REG_CACHE_START: ref_region.cache_start = data;
      REG_CACHE_END:   ref_region.cache_end = data;
      REG_SPM_START:   ref_region.spm_start = data;
      default:         return;
    endcase
    for (int i = 0; i < LLC_NUM_LINES; i++) begin
      ref_valid[i] = 1'b0;
    end
    // Flush pulse lands on the following edge
    idle_cycle();
  endtask

  task automatic cfg_read(input logic [CFG_ADDR_W-1:0] offset, output logic [DATA_W-1:0] data);
    cfg_access(1'b0, offset, '0, data);
  endtask

  task automatic expect_reg(input logic [CFG_ADDR_W-1:0] offset, input string name,
                            input logic [DATA_W-1:0] exp);
    logic [DATA_W-1:0] data;
    cfg_read(offset, data);
    check_eq(name, data, exp);
  endtask

  task automatic check_counters();
    // Counters trail the last access by one cycle
    idle_cycle();
    expect_reg(REG_RD_HIT, "rd_hit counter", ref_cnt[0]);
    expect_reg(REG_RD_MISS, "rd_miss counter", ref_cnt[1]);
    expect_reg(REG_WR_HIT, "wr_hit counter", ref_cnt[2]);
    expect_reg(REG_WR_MISS, "wr_miss counter", ref_cnt[3]);
  endtask

  task automatic read_reset_values();
    int err0;
    err0 = errors;
    expect_reg(REG_CACHE_START, "cache_start", 32'h0);
    expect_reg(REG_CACHE_END, "cache_end", 32'h0);
    expect_reg(REG_SPM_START, "spm_start", 32'hFFFF_FFFF);
    check_counters();
    expect_reg(8'h0C, "unmapped 0x0C", 32'hDEAD_F000);
    expect_reg(8'h20, "unmapped 0x20", 32'hDEAD_F000);
    report_test("reset_values", err0);
  endtask

  task automatic l2_write_readback();
    logic [ADDR_W-1:0] addrs [$];
    logic [ADDR_W-1:0] addr;
    int                err0;
    err0 = errors;
    for (int i = 0; i < 64; i++) begin
      addr = (($urandom() % 1024) << 5) | ((i % 8) << 2);
      addrs.push_back(addr);
      mem_write(addr, $urandom());
    end
    foreach (addrs[i]) begin
      check_mem(addrs[i]);
    end
    // 32 KiB higher wraps onto the same word
    mem_write(32'h0000_1234 & ~32'h3, 32'hA5A5_0F0F);
    check_mem(32'h0000_9234 & ~32'h3);
    report_test("l2_data", err0);
  endtask

  task automatic range_reg_readback();
    int err0;
    err0 = errors;
    cfg_write(REG_CACHE_START, 32'h0000_1000);
    cfg_write(REG_CACHE_END, 32'h0000_3000);
    cfg_write(REG_SPM_START, 32'h0000_6000);
    expect_reg(REG_CACHE_START, "cache_start", 32'h0000_1000);
    expect_reg(REG_CACHE_END, "cache_end", 32'h0000_3000);
    expect_reg(REG_SPM_START, "spm_start", 32'h0000_6000);
    cfg_write(REG_RD_HIT, 32'h1111_1111);
    cfg_write(REG_RD_MISS, 32'h2222_2222);
    cfg_write(REG_WR_HIT, 32'h3333_3333);
    cfg_write(REG_WR_MISS, 32'h4444_4444);
    check_counters();
    report_test("range_regs", err0);
  endtask

  task automatic count_hits_misses();
    logic [ADDR_W-1:0] addr;
    int                err0;
    err0 = errors;
    cfg_write(REG_CACHE_START, 32'h0000_0000);
    cfg_write(REG_CACHE_END, 32'h0000_4000);
    cfg_write(REG_SPM_START, 32'h0001_0000);
    // Two tags compete for three lines
    for (int i = 0; i < 48; i++) begin
      addr = (($urandom() % 2) << 13) | (($urandom() % 3) << 5) | (($urandom() % 8) << 2);
      if ($urandom() % 2 == 1) begin
        mem_write(addr, $urandom());
      end else begin
        check_mem(addr);
      end
    end
    check_counters();
    report_test("hit_miss", err0);
  endtask

  task automatic bypass_and_flush();
    logic [DATA_W-1:0] data;
    int                err0;
    err0 = errors;
    // Scratchpad start inside the cached range
    cfg_write(REG_SPM_START, 32'h0000_3000);
    mem_write(32'h0000_3000, 32'h0BAD_CAFE);
    mem_read(32'h0000_3F40, data);
    mem_read(32'h0000_5000, data);
    mem_write(32'h0000_4000, 32'h1234_5678);
    check_counters();
    mem_read(32'h0000_0040, data);
    mem_read(32'h0000_0040, data);
    cfg_write(REG_CACHE_END, 32'h0000_4000);
    mem_read(32'h0000_0040, data);
    check_counters();
    report_test("bypass_flush", err0);
  endtask

  initial begin
    void'($urandom(32'h0524b89f));
    errors = 0;
    checks = 0;
    tests = 0;
    mem_req = '0;
    cfg_req = '0;
    rst_i = 1'b1;
    ref_region = '{cache_start: '0, cache_end: '0, spm_start: 32'hFFFF_FFFF};
    ref_cnt = '{0, 0, 0, 0};
    for (int i = 0; i < LLC_NUM_LINES; i++) begin
      ref_valid[i] = 1'b0;
    end
    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    read_reset_values();
    l2_write_readback();
    range_reg_readback();
    count_hits_misses();
    bypass_and_flush();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/host_bus_pkg.sv
// Host memory path bus types
// Request and response records of the memory and configuration ports,
// plus the range settings and event bundle shared by the cache tracker
`default_nettype none

package host_bus_pkg;

  // Memory port request of one word per beat
  typedef struct packed {
    logic                             valid;
    logic                             we;
    logic [host_geom_pkg::ADDR_W-1:0] addr;
    logic [host_geom_pkg::DATA_W-1:0] wdata;
  } mem_req_t;

  // Memory port response one cycle after the request
  typedef struct packed {
    logic                             valid;
    logic [host_geom_pkg::DATA_W-1:0] rdata;
  } mem_rsp_t;

  // Configuration port request
  typedef struct packed {
    logic                                 valid;
    logic                                 we;
    logic [host_geom_pkg::CFG_ADDR_W-1:0] offset;
    logic [host_geom_pkg::DATA_W-1:0]     wdata;
  } cfg_req_t;

  // Configuration port response
  typedef struct packed {
    logic                             valid;
    logic [host_geom_pkg::DATA_W-1:0] rdata;
  } cfg_rsp_t;

  // Address ranges that steer the tracker
  // Cached range is half open with the end excluded
  typedef struct packed {
    logic [host_geom_pkg::ADDR_W-1:0] cache_start;
    logic [host_geom_pkg::ADDR_W-1:0] cache_end;
    logic [host_geom_pkg::ADDR_W-1:0] spm_start;
  } llc_region_t;

  // Tracker events with at most one high per cycle
  typedef struct packed {
    logic read_hit;
    logic read_miss;
    logic write_hit;
    logic write_miss;
  } llc_events_t;

endpackage

`default_nettype wire

// File: source/host_domain.sv
// Host domain memory path
// L2 banks serve the data, the tag tracker watches the same requests
// and the register block sets its ranges and counts its events
`timescale 1ns/100ps
`default_nettype none

module host_domain (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  host_bus_pkg::mem_req_t mem_req_i,
  output host_bus_pkg::mem_rsp_t mem_rsp_o,
  input  host_bus_pkg::cfg_req_t cfg_req_i,
  output host_bus_pkg::cfg_rsp_t cfg_rsp_o
);

  import host_bus_pkg::*;

  llc_region_t llc_region;
  llc_events_t llc_events;
  logic        llc_flush;

  l2_bank_array i_l2_bank_array (
    .clk_i     ( clk_i     ),
    .rst_i     ( rst_i     ),
    .mem_req_i ( mem_req_i ),
    .mem_rsp_o ( mem_rsp_o )
  );

  // Tracker only keeps bookkeeping and never supplies data
  llc_tag_tracker i_llc_tag_tracker (
    .clk_i     ( clk_i      ),
    .rst_i     ( rst_i      ),
    .mem_req_i ( mem_req_i  ),
    .region_i  ( llc_region ),
    .flush_i   ( llc_flush  ),
    .events_o  ( llc_events )
  );

  llc_cfg_regs i_llc_cfg_regs (
    .clk_i     ( clk_i      ),
    .rst_i     ( rst_i      ),
    .cfg_req_i ( cfg_req_i  ),
    .cfg_rsp_o ( cfg_rsp_o  ),
    .events_i  ( llc_events ),
    .region_o  ( llc_region ),
    .flush_o   ( llc_flush  )
  );

endmodule

`default_nettype wire

// File: source/host_geom_pkg.sv
// Host memory path geometry
// L2 bank layout, last-level-cache tag store shape and the
// configuration register map of the cache tracker
`default_nettype none

package host_geom_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // Byte offset inside a word
  localparam int unsigned WORD_OFF_W = $clog2(DATA_W / 8);

  // L2 memory word interleaved over the banks
  localparam int unsigned NB_L2_BANKS    = 8;
  localparam int unsigned L2_BANK_SIZE   = 1024;
  localparam int unsigned L2_BANK_ADDR_W = $clog2(L2_BANK_SIZE);
  localparam int unsigned BANK_SEL_W     = $clog2(NB_L2_BANKS);

  // Direct-mapped tag store
  localparam int unsigned LLC_NUM_LINES  = 256;
  localparam int unsigned LLC_NUM_BLOCKS = 8;
  localparam int unsigned LLC_INDEX_W    = $clog2(LLC_NUM_LINES);
  localparam int unsigned LINE_OFF_W     = WORD_OFF_W + $clog2(LLC_NUM_BLOCKS);
  localparam int unsigned LLC_TAG_W      = ADDR_W - LLC_INDEX_W - LINE_OFF_W;

  // Register map
  localparam int unsigned CFG_ADDR_W = 8;

  localparam logic [CFG_ADDR_W-1:0] REG_CACHE_START = 8'h00;
  localparam logic [CFG_ADDR_W-1:0] REG_CACHE_END   = 8'h04;
  localparam logic [CFG_ADDR_W-1:0] REG_SPM_START   = 8'h08;
  localparam logic [CFG_ADDR_W-1:0] REG_RD_HIT      = 8'h10;
  localparam logic [CFG_ADDR_W-1:0] REG_RD_MISS     = 8'h14;
  localparam logic [CFG_ADDR_W-1:0] REG_WR_HIT      = 8'h18;
  localparam logic [CFG_ADDR_W-1:0] REG_WR_MISS     = 8'h1C;

  // Read value of any offset outside the map
  localparam logic [DATA_W-1:0] CFG_UNMAPPED_DATA = 32'hDEAD_F000;

  // Scratchpad disabled out of reset
  localparam logic [ADDR_W-1:0] SPM_START_RESET = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// File: source/l2_bank_array.sv
// Banked L2 scratch memory
// Consecutive words go to consecutive banks, one bank is accessed per
// request and the read word comes back one cycle later
`timescale 1ns/100ps
`default_nettype none

module l2_bank_array (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  host_bus_pkg::mem_req_t mem_req_i,
  output host_bus_pkg::mem_rsp_t mem_rsp_o
);

  import host_geom_pkg::*;

  logic [BANK_SEL_W-1:0]     bank_sel;
  logic [L2_BANK_ADDR_W-1:0] row;
  logic [BANK_SEL_W-1:0]     bank_sel_q;
  logic                      rsp_valid_q;
  logic [DATA_W-1:0]         bank_rdata [NB_L2_BANKS];

  // Upper address bits are dropped, so the array wraps
  assign bank_sel = mem_req_i.addr[WORD_OFF_W +: BANK_SEL_W];
  assign row      = mem_req_i.addr[WORD_OFF_W + BANK_SEL_W +: L2_BANK_ADDR_W];

  for (genvar b = 0; b < NB_L2_BANKS; b++) begin : g_bank
    logic [DATA_W-1:0] mem_q [L2_BANK_SIZE];
    logic [DATA_W-1:0] rdata_q;
    logic              bank_en;

    assign bank_en = mem_req_i.valid && (bank_sel == BANK_SEL_W'(b));

    always_ff @(posedge clk_i) begin
      if (bank_en) begin
        if (mem_req_i.we) begin
          mem_q[row] <= mem_req_i.wdata;
        end else begin
          rdata_q <= mem_q[row];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk_i) begin
    if (mem_req_i.valid) begin
      bank_sel_q <= bank_sel;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= mem_req_i.valid;
    end
  end

  assign mem_rsp_o.valid = rsp_valid_q;
  assign mem_rsp_o.rdata = bank_rdata[bank_sel_q];

endmodule

`default_nettype wire

// File: source/llc_cfg_regs.sv
// Cache tracker configuration registers
// Holds the cached range and scratchpad start, counts hit and miss
// events and answers register accesses one cycle later
`timescale 1ns/100ps
`default_nettype none

module llc_cfg_regs (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  host_bus_pkg::cfg_req_t    cfg_req_i,
  output host_bus_pkg::cfg_rsp_t    cfg_rsp_o,
  input  host_bus_pkg::llc_events_t events_i,
  output host_bus_pkg::llc_region_t region_o,
  output logic                     flush_o
);

  import host_geom_pkg::*;
  import host_bus_pkg::*;

  llc_region_t       region_q;
  logic              flush_q;
  logic              wr_en;
  logic [DATA_W-1:0] rd_hit_cnt_q;
  logic [DATA_W-1:0] rd_miss_cnt_q;
  logic [DATA_W-1:0] wr_hit_cnt_q;
  logic [DATA_W-1:0] wr_miss_cnt_q;
  logic [DATA_W-1:0] rdata_d;
  logic [DATA_W-1:0] rdata_q;
  logic              rsp_valid_q;

  assign wr_en = cfg_req_i.valid && cfg_req_i.we;

  // Any range register write invalidates the tag store
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      region_q.cache_start <= '0;
      region_q.cache_end   <= '0;
      region_q.spm_start   <= SPM_START_RESET;
      flush_q              <= 1'b0;
    end else begin
      flush_q <= 1'b0;
      if (wr_en) begin
        case (cfg_req_i.offset)
          REG_CACHE_START: begin
            region_q.cache_start <= cfg_req_i.wdata;
            flush_q              <= 1'b1;
          end
          REG_CACHE_END: begin
            region_q.cache_end <= cfg_req_i.wdata;
            flush_q            <= 1'b1;
          end
          REG_SPM_START: begin
            region_q.spm_start <= cfg_req_i.wdata;
            flush_q            <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // Event counters are read only from the bus side
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_hit_cnt_q  <= '0;
      rd_miss_cnt_q <= '0;
      wr_hit_cnt_q  <= '0;
      wr_miss_cnt_q <= '0;
    end else begin
      if (events_i.read_hit)   rd_hit_cnt_q  <= rd_hit_cnt_q + 1'b1;
      if (events_i.read_miss)  rd_miss_cnt_q <= rd_miss_cnt_q + 1'b1;
      if (events_i.write_hit)  wr_hit_cnt_q  <= wr_hit_cnt_q + 1'b1;
      if (events_i.write_miss) wr_miss_cnt_q <= wr_miss_cnt_q + 1'b1;
    end
  end

  always_comb begin
    case (cfg_req_i.offset)
      REG_CACHE_START: rdata_d = region_q.cache_start;
      REG_CACHE_END:   rdata_d = region_q.cache_end;
      REG_SPM_START:   rdata_d = region_q.spm_start;
      REG_RD_HIT:      rdata_d = rd_hit_cnt_q;
      REG_RD_MISS:     rdata_d = rd_miss_cnt_q;
      REG_WR_HIT:      rdata_d = wr_hit_cnt_q;
      REG_WR_MISS:     rdata_d = wr_miss_cnt_q;
      default:         rdata_d = CFG_UNMAPPED_DATA;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= cfg_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_req_i.valid) begin
      rdata_q <= rdata_d;
    end
  end

  assign cfg_rsp_o.valid = rsp_valid_q;
  assign cfg_rsp_o.rdata = rdata_q;
  assign region_o        = region_q;
  assign flush_o         = flush_q;

endmodule

`default_nettype wire

// File: source/llc_tag_tracker.sv
// Last-level-cache hit and miss tracker
// Classifies each access against the cached range and the scratchpad
// start, looks it up in a direct-mapped tag store and flags the result
`timescale 1ns/100ps
`default_nettype none

module llc_tag_tracker (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  host_bus_pkg::mem_req_t    mem_req_i,
  input  host_bus_pkg::llc_region_t region_i,
  input  logic                      flush_i,
  output host_bus_pkg::llc_events_t events_o
);

  import host_geom_pkg::*;
  import host_bus_pkg::*;

  logic [LLC_INDEX_W-1:0]   index;
  logic [LLC_TAG_W-1:0]     tag;
  logic [LLC_TAG_W-1:0]     tag_q [LLC_NUM_LINES];
  logic [LLC_NUM_LINES-1:0] line_valid_q;
  logic                     is_spm;
  logic                     in_range;
  logic                     cached;
  logic                     hit;
  logic                     fill;
  llc_events_t              events_d;
  llc_events_t              events_q;

  assign index = mem_req_i.addr[LINE_OFF_W +: LLC_INDEX_W];
  assign tag   = mem_req_i.addr[LINE_OFF_W + LLC_INDEX_W +: LLC_TAG_W];

  // Scratchpad wins over the cached range
  assign is_spm   = mem_req_i.addr >= region_i.spm_start;
  assign in_range = (mem_req_i.addr >= region_i.cache_start) &&
                    (mem_req_i.addr < region_i.cache_end);
  assign cached   = mem_req_i.valid && !is_spm && in_range;

  assign hit  = line_valid_q[index] && (tag_q[index] == tag);
  // Reads and writes both allocate
  assign fill = cached && !hit;

  always_comb begin
    events_d            = '0;
    events_d.read_hit   = cached && !mem_req_i.we && hit;
    events_d.read_miss  = cached && !mem_req_i.we && !hit;
    events_d.write_hit  = cached && mem_req_i.we && hit;
    events_d.write_miss = cached && mem_req_i.we && !hit;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      line_valid_q <= '0;
    end else if (fill) begin
      line_valid_q[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill) begin
      tag_q[index] <= tag;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      events_q <= '0;
    end else begin
      events_q <= events_d;
    end
  end

  assign events_o = events_q;

endmodule

`default_nettype wire
